// File: hdl/store_pkg.sv
package store_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [31:0] data_word_t;                    // One data word of the core.
    typedef logic [31:0] address_t;                      // Byte address of the core.
    typedef logic [3:0]  byte_enable_t;                  // One bit per byte lane of a word.

    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } store_width_t;                                     // Store size as issued by the core.

    localparam int BYTE_LANES = 4;                       // Bytes in one data word.
    localparam byte_enable_t LANE_BYTE = 4'b0001;        // Byte mask before lane shift.
    localparam byte_enable_t LANE_HALF = 4'b0011;        // Half word mask before lane shift.
    localparam byte_enable_t LANE_WORD = 4'b1111;        // Full word mask.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Cache geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int CACHE_LINES = 16;                     // Direct mapped, one word per line.
    localparam int INDEX_BITS  = 4;                      // Selects one of the lines.
    localparam int INDEX_LSB   = 2;                      // Index sits above the byte offset.
    localparam int TAG_BITS    = 26;                     // Remaining upper address bits.
    localparam int TAG_LSB     = INDEX_LSB + INDEX_BITS; // Tag starts at bit 6.

    typedef logic [INDEX_BITS-1:0] cache_index_t;
    typedef logic [TAG_BITS-1:0]   cache_tag_t;

    // Store buffer sizing.
    localparam int BUFFER_DEPTH = 4;
    typedef logic [1:0] buffer_ptr_t;                    // Wraps naturally at four entries.

    typedef enum logic [1:0] {
        IDLE,
        OUTCOME,
        WRITE_THROUGH
    } controller_state_t;                                // Store controller FSM states.

endpackage : store_pkg

// File: hdl/store_issue.sv
`timescale 1ns/1ps

module store_issue import store_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         store_i,
    input  address_t     store_address_i,
    input  data_word_t   store_data_i,
    input  store_width_t store_width_i,
    input  logic         buffer_full_i,
    output logic         push_o,
    output address_t     push_address_o,
    output data_word_t   push_data_o,
    output store_width_t push_width_o,
    output logic         misaligned_o
);

    logic aligned;                                   // Store fits its natural boundary.

    always_comb begin : alignment_check
        case (store_width_i)
            BYTE:      aligned = 1'b1;               // Any byte address is fine.
            HALF_WORD: aligned = !store_address_i[0]; // Half words sit on even addresses.
            WORD:      aligned = (store_address_i[1:0] == 2'b00);
            default:   aligned = 1'b0;               // Unknown widths are rejected too.
        endcase
    end : alignment_check

    // Exactly one of push and misaligned pulses per accepted strobe.
    always_ff @(posedge clk_i) begin : strobe_register
        if (!rst_n_i) begin
            push_o       <= 1'b0;
            misaligned_o <= 1'b0;
        end else begin
            push_o       <= store_i && aligned;      // Good stores go to the buffer.
            misaligned_o <= store_i && !aligned;     // Bad stores are only flagged.
        end
    end : strobe_register

    always_ff @(posedge clk_i) begin : payload_register
        if (store_i) begin
            push_address_o <= store_address_i;       // Held until the next store.
            push_data_o    <= store_data_i;
            push_width_o   <= store_width_i;
        end
    end : payload_register

    // The core watches full_o, which is the buffer's full flag passed on.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_i |-> !buffer_full_i)
    else $error("store issued while the store buffer is full");

endmodule : store_issue

// File: hdl/store_buffer.sv
`timescale 1ns/1ps

module store_buffer import store_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         push_i,
    input  address_t     push_address_i,
    input  data_word_t   push_data_i,
    input  store_width_t push_width_i,
    input  logic         pop_i,
    output logic         full_o,
    output logic         not_empty_o,
    output address_t     head_address_o,
    output data_word_t   head_data_o,
    output store_width_t head_width_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    address_t     entry_address [BUFFER_DEPTH];      // Store addresses in issue order.
    data_word_t   entry_data    [BUFFER_DEPTH];      // Unshifted store data.
    store_width_t entry_width   [BUFFER_DEPTH];      // Store sizes.

    buffer_ptr_t write_ptr;                          // Next free slot.
    buffer_ptr_t read_ptr;                           // Oldest pending store.
    logic [2:0]  count;                              // Zero to four pending stores.

    always_ff @(posedge clk_i) begin : entry_write
        if (push_i) begin
            entry_address[write_ptr] <= push_address_i;
            entry_data[write_ptr]    <= push_data_i;
            entry_width[write_ptr]   <= push_width_i;
        end
    end : entry_write

    always_ff @(posedge clk_i) begin : pointer_update
        if (!rst_n_i) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (push_i) begin
                write_ptr <= write_ptr + 1'b1;       // Pointer wraps after the last slot.
            end
            if (pop_i) begin
                read_ptr <= read_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;      // Push only.
                2'b01:   count <= count - 1'b1;      // Pop only.
                default: count <= count;             // Both or neither leave it as is.
            endcase
        end
    end : pointer_update

    assign full_o      = (count == 3'(BUFFER_DEPTH));
    assign not_empty_o = (count != '0);              // Doubles as the controller request.

    // The head is visible one cycle after its push.
    assign head_address_o = entry_address[read_ptr];
    assign head_data_o    = entry_data[read_ptr];
    assign head_width_o   = entry_width[read_ptr];

    assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("push into a full store buffer");

    assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> not_empty_o)
    else $error("pop from an empty store buffer");

endmodule : store_buffer

// File: hdl/store_controller.sv
`timescale 1ns/1ps

module store_controller import store_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         halt_i,
    input  logic         request_i,
    input  address_t     head_address_i,
    input  data_word_t   head_data_i,
    input  store_width_t head_width_i,
    input  logic         cache_hit_i,
    input  logic         cache_dirty_i,
    input  logic         mem_done_i,
    output logic         valid_o,
    output logic         busy_o,
    output logic         cache_read_o,
    output address_t     cache_address_o,
    output logic         cache_write_data_o,
    output logic         cache_write_status_o,
    output logic         cache_status_valid_o,
    output logic         cache_status_dirty_o,
    output byte_enable_t cache_byte_o,
    output data_word_t   cache_data_o,
    output logic         mem_req_o,
    output address_t     mem_address_o,
    output store_width_t mem_width_o,
    output data_word_t   mem_data_o
);

    controller_state_t state_crt, state_nxt;

    always_ff @(posedge clk_i) begin : state_register
        if (!rst_n_i) begin
            state_crt <= IDLE;
        end else if (!halt_i) begin
            state_crt <= state_nxt;                  // A halt freezes the FSM in place.
        end
    end : state_register

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state and strobes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin : next_state
        state_nxt            = state_crt;
        valid_o              = 1'b0;
        mem_req_o            = 1'b0;
        cache_read_o         = 1'b0;
        cache_write_data_o   = 1'b0;
        cache_write_status_o = 1'b0;
        cache_status_valid_o = 1'b0;
        cache_status_dirty_o = 1'b0;

        if (!halt_i) begin                           // No strobe leaves while halted.
            case (state_crt)
                IDLE: begin
                    if (request_i) begin
                        state_nxt    = OUTCOME;
                        cache_read_o = 1'b1;         // Outcome is ready next cycle.
                    end
                end
                OUTCOME: begin
                    if (cache_hit_i) begin
                        state_nxt            = IDLE;
                        valid_o              = 1'b1; // Hit completes right here.
                        cache_write_data_o   = 1'b1;
                        cache_write_status_o = 1'b1;
                        cache_status_valid_o = 1'b1;
                        cache_status_dirty_o = 1'b1;
                    end else begin
                        state_nxt = WRITE_THROUGH;
                        mem_req_o = 1'b1;            // Miss goes straight to memory.
                        // A clean line is dropped, a dirty one is kept as it is.
                        cache_write_status_o = !cache_dirty_i;
                    end
                end
                WRITE_THROUGH: begin
                    if (mem_done_i) begin
                        state_nxt = IDLE;
                        valid_o   = 1'b1;            // Pops the head on this edge.
                    end
                end
                default: state_nxt = IDLE;
            endcase
        end
    end : next_state

    // Byte lanes follow the low address bits of the head entry.
    always_comb begin : lane_alignment
        case (head_width_i)
            BYTE: begin
                cache_byte_o = LANE_BYTE << head_address_i[1:0];
                cache_data_o = head_data_i << {head_address_i[1:0], 3'b000};
            end
            HALF_WORD: begin
                cache_byte_o = LANE_HALF << {head_address_i[1], 1'b0};
                cache_data_o = head_data_i << {head_address_i[1], 4'b0000};
            end
            WORD: begin
                cache_byte_o = LANE_WORD;
                cache_data_o = head_data_i;
            end
            default: begin
                cache_byte_o = '0;                   // Nothing is written.
                cache_data_o = head_data_i;
            end
        endcase
    end : lane_alignment

    assign busy_o          = (state_crt != IDLE);
    assign cache_address_o = head_address_i;         // Lookup and write share it.
    assign mem_address_o   = head_address_i;
    assign mem_width_o     = head_width_i;
    assign mem_data_o      = cache_data_o;           // Memory sees lane shifted data.

    // The memory only answers a request that is outstanding.
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_done_i |-> (state_crt == WRITE_THROUGH))
    else $error("mem_done_i outside of a write-through");

endmodule : store_controller

// File: hdl/store_cache_array.sv
`timescale 1ns/1ps

module store_cache_array import store_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         lookup_i,
    input  address_t     lookup_address_i,
    input  logic         write_data_i,
    input  logic         write_status_i,
    input  logic         status_valid_i,
    input  logic         status_dirty_i,
    input  byte_enable_t byte_i,
    input  data_word_t   data_i,
    input  logic         fill_i,
    input  address_t     fill_address_i,
    input  data_word_t   fill_data_i,
    input  logic         load_i,
    input  address_t     load_address_i,
    output logic         hit_o,
    output logic         dirty_o,
    output logic         load_hit_o,
    output data_word_t   load_data_o
);

    function automatic cache_index_t index_of(input address_t address);
        return address[INDEX_LSB +: INDEX_BITS];
    endfunction

    function automatic cache_tag_t tag_of(input address_t address);
        return address[TAG_LSB +: TAG_BITS];
    endfunction

    cache_tag_t             line_tag  [CACHE_LINES]; // Upper address bits per line.
    data_word_t             line_data [CACHE_LINES]; // One word per line.
    logic [CACHE_LINES-1:0] line_valid;
    logic [CACHE_LINES-1:0] line_dirty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Writes where a fill beats a store write to the same line
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin : status_update
        if (!rst_n_i) begin
            line_valid <= '0;                        // Every line starts out invalid.
            line_dirty <= '0;
        end else begin
            if (write_status_i) begin
                line_valid[index_of(lookup_address_i)] <= status_valid_i;
                line_dirty[index_of(lookup_address_i)] <= status_dirty_i;
            end
            if (fill_i) begin
                line_valid[index_of(fill_address_i)] <= 1'b1; // Refilled lines are clean.
                line_dirty[index_of(fill_address_i)] <= 1'b0;
            end
        end
    end : status_update

    always_ff @(posedge clk_i) begin : data_update
        if (write_data_i) begin
            for (int lane = 0; lane < BYTE_LANES; lane++) begin
                if (byte_i[lane]) begin              // Only enabled lanes change.
                    line_data[index_of(lookup_address_i)][8*lane +: 8] <= data_i[8*lane +: 8];
                end
            end
        end
        if (fill_i) begin
            line_tag[index_of(fill_address_i)]  <= tag_of(fill_address_i);
            line_data[index_of(fill_address_i)] <= fill_data_i;
        end
        if (load_i) begin
            load_data_o <= line_data[index_of(load_address_i)]; // Raw word, even on a miss.
        end
    end : data_update

    // Outcomes are registered, one cycle after each strobe.
    always_ff @(posedge clk_i) begin : lookup_register
        if (!rst_n_i) begin
            hit_o      <= 1'b0;
            dirty_o    <= 1'b0;
            load_hit_o <= 1'b0;
        end else begin
            if (lookup_i) begin
                hit_o   <= line_valid[index_of(lookup_address_i)]
                        && (line_tag[index_of(lookup_address_i)] == tag_of(lookup_address_i));
                dirty_o <= line_dirty[index_of(lookup_address_i)];
            end
            if (load_i) begin
                load_hit_o <= line_valid[index_of(load_address_i)]
                           && (line_tag[index_of(load_address_i)] == tag_of(load_address_i));
            end
        end
    end : lookup_register

endmodule : store_cache_array

// File: hdl/store_subsystem.sv
`timescale 1ns/1ps

module store_subsystem import store_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         halt_i,
    input  logic         store_i,
    input  address_t     store_address_i,
    input  data_word_t   store_data_i,
    input  store_width_t store_width_i,
    output logic         full_o,
    output logic         misaligned_o,
    output logic         store_done_o,
    output logic         busy_o,
    output logic         mem_req_o,
    output address_t     mem_address_o,
    output data_word_t   mem_data_o,
    output store_width_t mem_width_o,
    input  logic         mem_done_i,
    input  logic         fill_i,
    input  address_t     fill_address_i,
    input  data_word_t   fill_data_i,
    input  logic         load_i,
    input  address_t     load_address_i,
    output logic         load_hit_o,
    output data_word_t   load_data_o
);

    logic         push, buffer_not_empty, controller_busy;
    address_t     push_address, head_address, cache_address;
    data_word_t   push_data, head_data, cache_data;
    store_width_t push_width, head_width;
    logic         cache_read, cache_hit, cache_dirty;
    logic         write_data, write_status, status_valid, status_dirty;
    byte_enable_t cache_byte;

    store_issue issue (
        .clk_i, .rst_n_i, .store_i, .store_address_i, .store_data_i, .store_width_i,
        .buffer_full_i  (full_o),                    // Full flag goes back to the core.
        .push_o         (push),
        .push_address_o (push_address),
        .push_data_o    (push_data),
        .push_width_o   (push_width),
        .misaligned_o
    );

    store_buffer buffer (
        .clk_i, .rst_n_i, .full_o,
        .push_i         (push),
        .push_address_i (push_address),
        .push_data_i    (push_data),
        .push_width_i   (push_width),
        .pop_i          (store_done_o),              // Completion retires the head.
        .not_empty_o    (buffer_not_empty),
        .head_address_o (head_address),
        .head_data_o    (head_data),
        .head_width_o   (head_width)
    );

    store_controller controller (
        .clk_i, .rst_n_i, .halt_i, .mem_done_i,
        .request_i            (buffer_not_empty),
        .head_address_i       (head_address),
        .head_data_i          (head_data),
        .head_width_i         (head_width),
        .cache_hit_i          (cache_hit),
        .cache_dirty_i        (cache_dirty),
        .valid_o              (store_done_o),
        .busy_o               (controller_busy),
        .cache_read_o         (cache_read),
        .cache_address_o      (cache_address),
        .cache_write_data_o   (write_data),
        .cache_write_status_o (write_status),
        .cache_status_valid_o (status_valid),
        .cache_status_dirty_o (status_dirty),
        .cache_byte_o         (cache_byte),
        .cache_data_o         (cache_data),
        .mem_req_o, .mem_address_o, .mem_width_o, .mem_data_o
    );

    store_cache_array cache (
        .clk_i, .rst_n_i, .fill_i, .fill_address_i, .fill_data_i,
        .load_i, .load_address_i, .load_hit_o, .load_data_o,
        .lookup_i         (cache_read),
        .lookup_address_i (cache_address),
        .write_data_i     (write_data),
        .write_status_i   (write_status),
        .status_valid_i   (status_valid),
        .status_dirty_i   (status_dirty),
        .byte_i           (cache_byte),
        .data_i           (cache_data),
        .hit_o            (cache_hit),
        .dirty_o          (cache_dirty)
    );

    assign busy_o = controller_busy || buffer_not_empty; // Any store still in flight.

endmodule : store_subsystem

// File: bench/store_subsystem_tb.sv
`timescale 1ns/1ps

module store_subsystem_tb import store_pkg::*; ();

    localparam int HALF_PERIOD    = 20;              // 40 ns clock period.
    localparam int TIMEOUT_CYCLES = 600;             // Longest any single wait may take.

    logic         clk_i = 1'b0, rst_n_i, halt_i, store_i, fill_i, load_i;
    logic         full_o, misaligned_o, store_done_o, busy_o, mem_req_o, load_hit_o;
    logic         mem_done_i = 1'b0;                 // Driven by the memory responder.
    address_t     store_address_i, fill_address_i, load_address_i, mem_address_o;
    data_word_t   store_data_i, fill_data_i, mem_data_o, load_data_o;
    store_width_t store_width_i, mem_width_o;

    logic [31:0]  lfsr_state = 32'd75353;            // Galois LFSR seed.
    logic         mem_hold   = 1'b0;                 // Holds back mem_done_i while set.
    cache_tag_t   model_tag   [CACHE_LINES];         // Reference cache lines.
    data_word_t   model_data  [CACHE_LINES];
    logic         model_valid [CACHE_LINES];
    logic         model_dirty [CACHE_LINES];
    address_t     exp_address [$];                   // Expected memory requests in order.
    data_word_t   exp_data    [$];
    store_width_t exp_width   [$];
    bit           done_miss   [$];                   // One per pending store, set for a miss.
    int           reply_delays[$];                   // Cycles until each mem_done_i.
    int           requests_seen = 0, misses_done = 0;
    cache_tag_t   tag_home, tag_away, tag_fresh;

    store_subsystem DUT (.*);

    always #(HALF_PERIOD) clk_i = ~clk_i;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source, failure and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic data_word_t random_bits(input int count);
        data_word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin    // One LFSR step per bit taken.
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hA300_0000) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_address(input string name, input address_t got, input address_t exp);
        if (got !== exp) abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_width(input string name, input store_width_t got,
                                 input store_width_t exp);
        if (got !== exp) abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic int width_bytes(input store_width_t width);
        return (width == BYTE) ? 1 : (width == HALF_WORD) ? 2 : 4;
    endfunction

    // Places the low bytes of the data on the lanes that the address selects.
    function automatic data_word_t lane_data(input address_t address, input data_word_t data,
                                             input store_width_t width,
                                             output data_word_t bit_mask);
        data_word_t shifted;
        shifted  = '0;
        bit_mask = '0;
        for (int k = 0; k < width_bytes(width); k++) begin
            shifted[8*(int'(address[1:0])+k) +: 8]  = data[8*k +: 8];
            bit_mask[8*(int'(address[1:0])+k) +: 8] = 8'hFF;
        end
        return shifted;
    endfunction

    task automatic predict_store(input address_t address, input data_word_t data,
                                 input store_width_t width);
        cache_index_t index;
        data_word_t   shifted, bit_mask;
        index   = address[5:2];
        shifted = lane_data(address, data, width, bit_mask);
        if (model_valid[index] && model_tag[index] == address[31:6]) begin
            model_data[index]  = (model_data[index] & ~bit_mask) | shifted; // Hit merges.
            model_dirty[index] = 1'b1;
            done_miss.push_back(1'b0);
        end else begin
            exp_address.push_back(address);       // A miss writes through.
            exp_data.push_back(shifted);
            exp_width.push_back(width);
            if (!model_dirty[index]) model_valid[index] = 1'b0; // Clean lines are dropped.
            done_miss.push_back(1'b1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus tasks that drive on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic issue_store(input address_t address, input data_word_t data,
                               input store_width_t width);
        int   cycles;
        logic misaligned;
        cycles     = 0;
        misaligned = (width == HALF_WORD && address[0]) || (width == WORD && address[1:0] != 0);
        while (full_o) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout waiting for full_o to fall");
        end
        if (!misaligned) predict_store(address, data, width);
        store_i         = 1'b1;
        store_address_i = address;
        store_data_i    = data;
        store_width_i   = width;
        @(negedge clk_i);
        store_i = 1'b0;
        compare_bit("misaligned_o", misaligned_o, misaligned);
        @(negedge clk_i);                            // The push lands before full_o is read again.
    endtask

    task automatic random_store(input cache_tag_t tag);
        store_width_t width;
        logic [1:0]   offset;
        width  = (random_bits(2) == 0) ? BYTE : (random_bits(1) == 0) ? HALF_WORD : WORD;
        offset = 2'(random_bits(2));
        if (width == HALF_WORD) offset[0] = 1'b0;
        if (width == WORD) offset = 2'b00;
        issue_store({tag, cache_index_t'(random_bits(4)), offset},
                    random_bits(8 * width_bytes(width)), width); // Data is zero extended.
    endtask

    task automatic fill_line(input address_t address, input data_word_t data);
        fill_i         = 1'b1;
        fill_address_i = address;
        fill_data_i    = data;
        model_tag[address[5:2]]   = address[31:6];
        model_data[address[5:2]]  = data;
        model_valid[address[5:2]] = 1'b1;
        model_dirty[address[5:2]] = 1'b0;
        @(negedge clk_i);
        fill_i = 1'b0;
    endtask

    task automatic check_load(input address_t address);
        logic hit;
        hit = model_valid[address[5:2]] && (model_tag[address[5:2]] == address[31:6]);
        load_i         = 1'b1;
        load_address_i = address;
        @(negedge clk_i);
        load_i = 1'b0;
        compare_bit("load_hit_o", load_hit_o, hit);
        if (hit) compare_word("load_data_o", load_data_o, model_data[address[5:2]]);
    endtask

    task automatic check_all_lines();
        for (int i = 0; i < CACHE_LINES; i++) begin
            check_load({tag_home, cache_index_t'(i), 2'b00});
            check_load({tag_away, cache_index_t'(i), 2'b00});
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy_o || done_miss.size() != 0) begin
            @(negedge clk_i);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) abort_run("timeout waiting for the stores to drain");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output monitor and memory responder
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always begin : output_monitor
        @(negedge clk_i);
        #(HALF_PERIOD / 2);                          // Outputs have settled by mid low phase.
        if (rst_n_i) begin
            if (halt_i && (store_done_o || mem_req_o)) abort_run("store path moved while halted");
            if (mem_req_o) begin
                if (exp_address.size() == 0 || !done_miss[0] || requests_seen != misses_done)
                    abort_run("memory request that no pending miss explains");
                compare_address("mem_address_o", mem_address_o, exp_address.pop_front());
                compare_word("mem_data_o", mem_data_o, exp_data.pop_front());
                compare_width("mem_width_o", mem_width_o, exp_width.pop_front());
                requests_seen++;
                reply_delays.push_back(int'(random_bits(3))); // Zero to seven cycles.
            end
            if (store_done_o) begin
                if (done_miss.size() == 0) abort_run("completion with no store pending");
                if (done_miss[0] && requests_seen == misses_done)
                    abort_run("miss completed before its memory request");
                if (done_miss.pop_front()) misses_done++;
            end
        end
    end : output_monitor

    always @(negedge clk_i) begin : memory_responder
        mem_done_i = 1'b0;
        if (rst_n_i && !mem_hold && reply_delays.size() != 0) begin
            if (reply_delays[0] == 0) begin
                mem_done_i = 1'b1;                   // One cycle pulse.
                void'(reply_delays.pop_front());
            end else begin
                reply_delays[0] = reply_delays[0] - 1;
            end
        end
    end : memory_responder

    initial begin : main_sequence
        rst_n_i = 1'b0;
        {halt_i, store_i, fill_i, load_i} = '0;
        {store_address_i, fill_address_i, load_address_i} = '0;
        {store_data_i, fill_data_i} = '0;
        store_width_i = BYTE;
        for (int i = 0; i < CACHE_LINES; i++) begin
            {model_valid[i], model_dirty[i], model_tag[i], model_data[i]} = '0;
        end
        tag_home  = cache_tag_t'(random_bits(TAG_BITS));
        tag_away  = tag_home ^ 26'h1;                // Same lines, other tag.
        tag_fresh = tag_home ^ 26'h2;                // Never filled, always misses.
        repeat (5) @(negedge clk_i);
        rst_n_i = 1'b1;

        compare_bit("busy_o", busy_o, 1'b0);         // Quiet after reset.
        compare_bit("full_o", full_o, 1'b0);
        compare_bit("mem_req_o", mem_req_o, 1'b0);
        compare_bit("store_done_o", store_done_o, 1'b0);
        compare_bit("misaligned_o", misaligned_o, 1'b0);
        repeat (6) check_load(random_bits(32));      // Every line starts invalid.

        for (int i = 0; i < CACHE_LINES; i++) fill_line({tag_home, cache_index_t'(i), 2'b00},
                                                        random_bits(32));
        repeat (24) random_store(tag_home);          // Hits only.
        wait_idle();
        check_all_lines();

        repeat (8) fill_line({random_bits(1) ? tag_home : tag_away,
                              cache_index_t'(random_bits(4)), 2'b00}, random_bits(32));
        repeat (24) random_store(random_bits(1) ? tag_home : tag_away); // Hits and misses.
        wait_idle();
        check_all_lines();

        repeat (8) begin                             // Misaligned half words and words.
            if (random_bits(1)) begin
                issue_store({tag_home, cache_index_t'(random_bits(4)), random_bits(1) == 1,
                            1'b1}, random_bits(16), HALF_WORD);
            end else begin
                issue_store({tag_home, cache_index_t'(random_bits(4)), 2'(random_bits(2) % 3 + 1)},
                            random_bits(32), WORD);
            end
        end
        wait_idle();
        check_all_lines();

        mem_hold <= 1'b1;                            // Back pressure from a slow memory.
        repeat (4) random_store(tag_fresh);
        compare_bit("full_o", full_o, 1'b1);
        repeat (10) @(negedge clk_i);
        mem_hold <= 1'b0;
        wait_idle();
        check_all_lines();

        halt_i = 1'b1;
        repeat (3) random_store(random_bits(1) ? tag_home : tag_fresh);
        repeat (10) @(negedge clk_i);
        compare_bit("busy_o", busy_o, 1'b1);         // Stores wait in the buffer.
        halt_i = 1'b0;
        wait_idle();
        check_all_lines();

        repeat (3) random_store(random_bits(1) ? tag_home : tag_fresh);
        mem_hold <= 1'b1;                            // No reply may land while halted.
        @(negedge clk_i);
        halt_i = 1'b1;                               // Stops the controller with stores pending.
        repeat (10) @(negedge clk_i);
        halt_i = 1'b0;
        mem_hold <= 1'b0;
        wait_idle();
        check_all_lines();

        $display("Everything OK");
        $finish;
    end : main_sequence

endmodule : store_subsystem_tb

// File: compile.f
hdl/store_pkg.sv
hdl/store_issue.sv
hdl/store_buffer.sv
hdl/store_controller.sv
hdl/store_cache_array.sv
hdl/store_subsystem.sv
bench/store_subsystem_tb.sv

// File: Makefile
# Verilator build for the store path of the data cache.
# Any variable below can be overridden on the command line, e.g. make sim TOP=...

TOP       ?= store_subsystem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= build
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The testbench ends every failing run with $fatal, so the exit status is the verdict.
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
